//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := tb_ice_app
FLIST     := flist.f
OBJ_DIR   := obj_dir
PASS_MSG  := all tests passed

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Status comes from the search for the pass line
run: $(SIM_BIN)
	$(SIM_BIN) | tee /dev/stderr | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
rtl/ice_pkg.sv
rtl/fifo_link_if.sv
rtl/spi_msg_rx.sv
rtl/cmd_exec.sv
rtl/pixel_pattern_src.sv
rtl/readout_fifo_stage.sv
rtl/spi_tx.sv
rtl/ice_app.sv
tests/tb_clk_gen.sv
tests/tb_ice_app.sv

//--- rtl/cmd_exec.sv
`timescale 1ns/10ps

module cmd_exec (
    input  logic                        img_clk,
    input  logic                        spi_rst_,
    input  ice_pkg::msg_t               msg,
    input  logic                        msg_valid,
    output logic [3:0]                  ice_led = 4'h0,
    output ice_pkg::resp_t              resp,
    output logic                        resp_load,
    output logic                        start,
    output ice_pkg::count_t             word_count,
    output logic [ice_pkg::pixel_w-1:0] pattern_start
);
    import ice_pkg::*;

    resp_t resp_next;
    logic  is_led_set;
    logic  is_readout;

    assign is_led_set = (msg.msg_type == msg_led_set);
    assign is_readout = (msg.msg_type == msg_readout);

    // ==================================================
    // Response build
    // ==================================================
    always_comb begin
        resp_next = '0;
        case (msg.msg_type)
            msg_echo: begin
                resp_next = {msg_echo, msg.arg.payload};
            end
            msg_led_set: begin
                resp_next = {msg_led_set, 52'h0, msg.arg.ctrl.led};
            end
            msg_readout: begin
                // Echo the count back so the host knows how much to drain
                resp_next = {msg_readout, 40'h0, msg.arg.ctrl.word_count};
            end
            msg_nop: begin
                resp_next = {msg_nop, 56'h0};
            end
            default: begin
                resp_next = {resp_bad_type, 56'h0};
            end
        endcase
    end

    // ==================================================
    // Pulses to the port and the readout source
    // ==================================================
    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            resp_load <= 1'b0;
            start     <= 1'b0;
        end else begin
            resp_load <= msg_valid;
            // Empty readout sends the response only
            start     <= msg_valid && is_readout && (msg.arg.ctrl.word_count != '0);
        end
    end

    always_ff @(posedge img_clk) begin
        if (msg_valid) begin
            resp          <= resp_next;
            word_count    <= msg.arg.ctrl.word_count;
            pattern_start <= msg.arg.ctrl.pattern_start;
        end
    end

    // LEDs survive the frame reset
    always_ff @(posedge img_clk) begin
        if (msg_valid && is_led_set) begin
            ice_led <= msg.arg.ctrl.led;
        end
    end

endmodule

//--- rtl/fifo_link_if.sv
`timescale 1ns/10ps

// One word link between readout stages
interface fifo_link_if;
    import ice_pkg::*;

    logic              trigger;   // Word present
    logic              ready;     // Downstream can take it
    logic [word_w-1:0] data;
    logic              last;      // Final word of the readout

    // Producer side
    modport src (
        output trigger,
        output data,
        output last,
        input  ready
    );

    // Consumer side
    modport dst (
        input  trigger,
        input  data,
        input  last,
        output ready
    );
endinterface

//--- rtl/ice_app.sv
`timescale 1ns/10ps

module ice_app #(
    parameter int stage_count = 4
) (
    input  logic       img_clk,
    input  logic       spi_rst_,
    input  logic [3:0] spi_din,
    output logic [7:0] spi_dout,
    output logic       spi_dout_en,
    output logic [3:0] ice_led
);
    import ice_pkg::*;

    msg_t               msg;
    logic               msg_valid;
    resp_t              resp;
    logic               resp_load;
    logic               start;
    count_t             word_count;
    logic [pixel_w-1:0] pattern_start;

    // Link 0 from the source, last link to the port
    fifo_link_if link [0:stage_count] ();

    // ==================================================
    // Command side
    // ==================================================
    spi_msg_rx msg_rx_i (
        .img_clk   (img_clk),
        .spi_rst_  (spi_rst_),
        .spi_din   (spi_din),
        .msg       (msg),
        .msg_valid (msg_valid)
    );

    cmd_exec cmd_exec_i (
        .img_clk       (img_clk),
        .spi_rst_      (spi_rst_),
        .msg           (msg),
        .msg_valid     (msg_valid),
        .ice_led       (ice_led),
        .resp          (resp),
        .resp_load     (resp_load),
        .start         (start),
        .word_count    (word_count),
        .pattern_start (pattern_start)
    );

    // ==================================================
    // Readout chain
    // ==================================================
    pixel_pattern_src pattern_i (
        .img_clk       (img_clk),
        .spi_rst_      (spi_rst_),
        .start         (start),
        .word_count    (word_count),
        .pattern_start (pattern_start),
        .out           (link[0])
    );

    for (genvar k = 0; k < stage_count; k++) begin : g_stage
        readout_fifo_stage stage_i (
            .img_clk  (img_clk),
            .spi_rst_ (spi_rst_),
            .up       (link[k]),
            .down     (link[k+1])
        );
    end

    spi_tx tx_i (
        .img_clk     (img_clk),
        .spi_rst_    (spi_rst_),
        .resp        (resp),
        .resp_load   (resp_load),
        .in          (link[stage_count]),
        .spi_dout    (spi_dout),
        .spi_dout_en (spi_dout_en)
    );

endmodule

//--- rtl/ice_pkg.sv
package ice_pkg;

    // ==================================================
    // Message port
    // ==================================================
    localparam int nibble_w = 4;
    localparam int msg_len  = 64;     // 16 nibbles per message

    typedef logic [7:0] msg_type_t;   // Top byte of every message

    localparam msg_type_t msg_echo      = 8'h00;
    localparam msg_type_t msg_led_set   = 8'h01;
    localparam msg_type_t msg_readout   = 8'h02;
    localparam msg_type_t msg_nop       = 8'h03;
    localparam msg_type_t resp_bad_type = 8'hFF;

    // Control view of the argument, MSB first
    typedef struct packed {
        logic [3:0]  led;
        logic [15:0] word_count;
        logic [11:0] pattern_start;
        logic [23:0] unused;
    } msg_ctrl_t;

    // Echo returns the raw argument, the other commands read fields
    typedef union packed {
        logic [55:0] payload;
        msg_ctrl_t   ctrl;
    } msg_arg_t;

    typedef struct packed {
        msg_type_t msg_type;
        msg_arg_t  arg;
    } msg_t;

    // Response goes out as 8 bytes, MSB first
    typedef logic [63:0] resp_t;

    // ==================================================
    // Readout path
    // ==================================================
    localparam int pixel_w = 12;
    localparam int word_w  = 16;      // Pixel zero-extended

    typedef logic [15:0] count_t;

endpackage

//--- rtl/pixel_pattern_src.sv
`timescale 1ns/10ps

module pixel_pattern_src (
    input  logic                        img_clk,
    input  logic                        spi_rst_,
    input  logic                        start,
    input  ice_pkg::count_t             word_count,
    input  logic [ice_pkg::pixel_w-1:0] pattern_start,
    fifo_link_if.src                    out
);
    import ice_pkg::*;

    logic               busy;
    count_t             remain;    // Words left including current one
    logic [pixel_w-1:0] pix;
    logic               accept;

    assign accept = busy && out.ready;

    assign out.trigger = busy;
    assign out.data    = {{(word_w - pixel_w){1'b0}}, pix};
    assign out.last    = (remain == count_t'(1));

    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (accept && out.last) begin
            busy <= 1'b0;
        end
    end

    // ==================================================
    // Pattern counter, wraps at 12 bits
    // ==================================================
    always_ff @(posedge img_clk) begin
        if (start) begin
            remain <= word_count;
            pix    <= pattern_start;
        end else if (accept) begin
            remain <= remain - 1'b1;
            pix    <= pix + 1'b1;
        end
    end

endmodule

//--- rtl/readout_fifo_stage.sv
`timescale 1ns/10ps

module readout_fifo_stage (
    input  logic     img_clk,
    input  logic     spi_rst_,
    fifo_link_if.dst up,
    fifo_link_if.src down
);
    import ice_pkg::*;

    logic              full;
    logic [word_w-1:0] data_q;
    logic              last_q;
    logic              take;

    // Ready when empty or when the held word leaves this cycle
    assign up.ready = !full || down.ready;
    assign take     = up.trigger && up.ready;

    assign down.trigger = full;
    assign down.data    = data_q;
    assign down.last    = last_q;

    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            full <= 1'b0;
        end else if (take) begin
            full <= 1'b1;
        end else if (down.ready) begin
            full <= 1'b0;                   // Drained, nothing new
        end
    end

    always_ff @(posedge img_clk) begin
        if (take) begin
            data_q <= up.data;
            last_q <= up.last;
        end
    end

endmodule

//--- rtl/spi_msg_rx.sv
`timescale 1ns/10ps

module spi_msg_rx (
    input  logic                         img_clk,
    input  logic                         spi_rst_,
    input  logic [ice_pkg::nibble_w-1:0] spi_din,
    output ice_pkg::msg_t                msg,
    output logic                         msg_valid
);
    import ice_pkg::*;

    localparam int nib_count = msg_len / nibble_w;
    localparam int cnt_w     = $clog2(nib_count + 1);

    logic [cnt_w-1:0] nib_cnt;
    logic             done;

    assign done = (nib_cnt == cnt_w'(nib_count));   // Rest of frame is ignored

    // ==================================================
    // Nibble counter
    // ==================================================
    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            nib_cnt   <= '0;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            if (!done) begin
                nib_cnt <= nib_cnt + 1'b1;
                // Last nibble sampled on this edge
                if (nib_cnt == cnt_w'(nib_count - 1)) begin
                    msg_valid <= 1'b1;
                end
            end
        end
    end

    // ==================================================
    // Shift register
    // ==================================================
    always_ff @(posedge img_clk) begin
        if (!done) begin
            msg <= {msg[msg_len-nibble_w-1:0], spi_din};   // MS nibble first
        end
    end

endmodule

//--- rtl/spi_tx.sv
`timescale 1ns/10ps

module spi_tx (
    input  logic           img_clk,
    input  logic           spi_rst_,
    input  ice_pkg::resp_t resp,
    input  logic           resp_load,
    fifo_link_if.dst       in,
    output logic [7:0]     spi_dout,
    output logic           spi_dout_en
);
    import ice_pkg::*;

    localparam int resp_bytes = $bits(resp_t) / 8;

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_resp = 2'd1;
    localparam logic [1:0] st_data = 2'd2;   // Draining the chain

    logic [1:0] state;
    logic [2:0] bcnt;       // Response bytes already sent
    logic       low_pend;   // Second byte of a word still to go
    resp_t      sh;
    logic [7:0] low_byte;
    logic       last_q;
    logic       take_word;
    logic       send_lo;

    assign in.ready  = (state == st_data) && !low_pend;
    assign take_word = in.trigger && in.ready;
    assign send_lo   = (state == st_data) && low_pend;

    // ==================================================
    // Control
    // ==================================================
    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state       <= st_idle;
            bcnt        <= '0;
            low_pend    <= 1'b0;
            spi_dout_en <= 1'b0;
        end else begin
            spi_dout_en <= 1'b0;
            if (resp_load) begin
                state       <= st_resp;
                bcnt        <= 3'd1;
                low_pend    <= 1'b0;
                spi_dout_en <= 1'b1;        // First byte goes out now
            end else begin
                case (state)
                    st_resp: begin
                        spi_dout_en <= 1'b1;
                        bcnt        <= bcnt + 1'b1;
                        if (bcnt == 3'(resp_bytes - 1)) begin
                            state <= st_data;
                        end
                    end
                    st_data: begin
                        if (send_lo) begin
                            spi_dout_en <= 1'b1;
                            low_pend    <= 1'b0;
                            if (last_q) state <= st_idle;
                        end else if (take_word) begin
                            spi_dout_en <= 1'b1;
                            low_pend    <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // ==================================================
    // Byte lane
    // ==================================================
    always_ff @(posedge img_clk) begin
        if (resp_load) begin
            spi_dout <= resp[63:56];
            sh       <= {resp[55:0], 8'h00};
        end else if (state == st_resp) begin
            spi_dout <= sh[63:56];
            sh       <= {sh[55:0], 8'h00};
        end else if (take_word) begin
            spi_dout <= in.data[word_w-1 -: 8];     // High byte first
            low_byte <= in.data[7:0];
            last_q   <= in.last;
        end else if (send_lo) begin
            spi_dout <= low_byte;
        end
    end

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/10ps

// Free-running clock for the testbench
module tb_clk_gen #(
    parameter real period_ns = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;   // 50% duty
    end

endmodule

//--- tests/tb_ice_app.sv
`timescale 1ns/10ps

module tb_ice_app;
    import ice_pkg::*;

    logic       img_clk;
    logic       spi_rst_ = 1'b0;
    logic [3:0] spi_din  = 4'h0;
    logic [7:0] spi_dout;
    logic       spi_dout_en;
    logic [3:0] ice_led;

    // Stimulus table with one row per frame
    string       name_q[$];
    logic [7:0]  type_q[$];
    logic [55:0] arg_q[$];
    logic [63:0] resp_q[$];
    int          words_q[$];
    logic [11:0] start_q[$];

    logic [3:0]  exp_led      = 4'h0;   // LEDs power up dark
    int          limit_cycles = 0;

    tb_clk_gen #(.period_ns(4.0)) clk_gen_i (.clk(img_clk));

    ice_app #(.stage_count(4)) ice_app_i (
        .img_clk     (img_clk),
        .spi_rst_    (spi_rst_),
        .spi_din     (spi_din),
        .spi_dout    (spi_dout),
        .spi_dout_en (spi_dout_en),
        .ice_led     (ice_led)
    );

    // ==================================================
    // Failure reporting
    // ==================================================
    task automatic report_error(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] exp_val,
                                   input logic [63:0] act_val);
        report_error($sformatf("FAIL %s: expected %0h, actual %0h", what, exp_val, act_val));
    endtask

    // ==================================================
    // Table
    // ==================================================
    task automatic add_entry(input string name, input logic [7:0] msg_type,
                             input logic [55:0] arg, input logic [63:0] resp,
                             input int words, input logic [11:0] start);
        name_q.push_back(name);
        type_q.push_back(msg_type);
        arg_q.push_back(arg);
        resp_q.push_back(resp);
        words_q.push_back(words);
        start_q.push_back(start);
    endtask

    task automatic build_table;
        // Argument fields are led, word_count, pattern_start and unused
        add_entry("echo", msg_echo, 56'h5A_C396_0FE1_247B,
                  64'h005A_C396_0FE1_247B, 0, 12'h000);
        add_entry("led_set", msg_led_set, {4'hA, 16'h1234, 12'h567, 24'h89ABCD},
                  64'h0100_0000_0000_000A, 0, 12'h000);
        add_entry("bad_type", 8'h5C, {4'hF, 16'd7, 12'h000, 24'h0},
                  64'hFF00_0000_0000_0000, 0, 12'h000);
        add_entry("short_readout", msg_readout, {4'hC, 16'd5, 12'h0FE, 24'h0},
                  64'h0200_0000_0000_0005, 5, 12'h0FE);
        add_entry("long_readout", msg_readout, {4'h0, 16'd40, 12'hFF8, 24'h0},
                  64'h0200_0000_0000_0028, 40, 12'hFF8);
        add_entry("nop", msg_nop, {4'h7, 16'd3, 12'h123, 24'hFFFFFF},
                  64'h0300_0000_0000_0000, 0, 12'h000);
        add_entry("zero_readout", msg_readout, {4'h0, 16'd0, 12'h456, 24'h0},
                  64'h0200_0000_0000_0000, 0, 12'h000);
        add_entry("led_set_2", msg_led_set, {4'h3, 16'h0, 12'h000, 24'h0},
                  64'h0100_0000_0000_0003, 0, 12'h000);
    endtask

    // ==================================================
    // One frame with reset, message, response and readout
    // ==================================================
    task automatic run_entry(input int e);
        logic [63:0] frame;
        logic [7:0]  exp_q[$];
        logic [11:0] pix;
        logic [15:0] word;
        logic        mid_burst;
        int          i;
        int          got;
        int          quiet;

        frame = {type_q[e], arg_q[e]};
        for (i = 7; i >= 0; i--) begin
            exp_q.push_back(resp_q[e][i*8 +: 8]);   // Response MSB first
        end
        for (i = 0; i < words_q[e]; i++) begin
            pix  = start_q[e] + 12'(i);              // Wraps at 12 bits
            word = {4'h0, pix};
            exp_q.push_back(word[15:8]);
            exp_q.push_back(word[7:0]);
        end

        // Frame reset keeps the LEDs
        @(posedge img_clk);
        spi_rst_ <= 1'b0;
        spi_din  <= 4'h0;
        @(negedge img_clk);
        assert (ice_led === exp_led)
            else report_mismatch($sformatf("%s led in reset", name_q[e]), exp_led, ice_led);
        repeat (4) @(posedge img_clk);

        spi_rst_ <= 1'b1;
        spi_din  <= frame[63:60];
        for (i = 14; i >= 0; i--) begin
            @(posedge img_clk);
            spi_din <= frame[i*4 +: 4];
        end

        got = 0;
        while (got < exp_q.size()) begin
            @(negedge img_clk);
            // Response bytes and word halves come back to back
            mid_burst = (got > 0 && got < 8) || (got > 8 && (got % 2) == 1);
            assert (spi_dout_en || !mid_burst)
                else report_error($sformatf("%s: gap in output after byte %0d",
                                            name_q[e], got - 1));
            if (spi_dout_en) begin
                assert (spi_dout === exp_q[got])
                    else report_mismatch($sformatf("%s byte %0d", name_q[e], got),
                                         exp_q[got], spi_dout);
                got++;
            end
        end

        quiet = (words_q[e] > 0) ? 20 : 8;
        repeat (quiet) begin
            @(negedge img_clk);
            assert (!spi_dout_en)
                else report_error($sformatf("%s: extra output byte after the transfer",
                                            name_q[e]));
        end

        if (type_q[e] == msg_led_set) begin
            exp_led = arg_q[e][55:52];
        end
        assert (ice_led === exp_led)
            else report_mismatch($sformatf("%s led", name_q[e]), exp_led, ice_led);
    endtask

    // ==================================================
    // Main sequence and watchdog
    // ==================================================
    initial begin
        int e;
        int budget;

        build_table();
        budget = 0;
        for (e = 0; e < name_q.size(); e++) begin
            budget += 40 + 3 * words_q[e];       // Per frame allowance
        end
        limit_cycles = budget;

        for (e = 0; e < name_q.size(); e++) begin
            run_entry(e);
        end
        $display("all tests passed");
        $finish;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge img_clk);
        report_error($sformatf("timeout: run did not finish within %0d cycles", limit_cycles));
    end

endmodule
